// File: verilog/uart_rx_pkg.sv
/*
 Shared definitions for the UART receive peripheral.
 Width typedefs, register map constants, signature word
 and the event and status structs.
*/

package uart_rx_pkg;

	// One received character.
	typedef logic [7:0] byte_t;

	// Read data word of the register port.
	typedef logic [31:0] bus_word_t;

	// Register address.
	typedef logic [1:0] reg_addr_t;

	// Register map.
	localparam reg_addr_t ADDR_DATA   = 2'd0;
	localparam reg_addr_t ADDR_STATUS = 2'd1;
	localparam reg_addr_t ADDR_FLUSH  = 2'd2;

	// Status word bit positions, all other bits read as zero.
	localparam int STATUS_EMPTY_BIT = 1;
	localparam int STATUS_FULL_BIT  = 2;

	// Returned by a flush read.
	localparam bus_word_t FLUSH_SIGNATURE = 32'hcafe_babe;

	// Event from the deserializer.
	typedef struct packed {
		logic  strobe;
		byte_t data;
		logic  soft_reset;
	} rx_event_t;

	// FIFO fill flags.
	typedef struct packed {
		logic empty;
		logic full;
	} fifo_status_t;

endpackage

// File: verilog/uart_rx_sampler.sv
/*
 Serial 8N1 deserializer.
 Prescaled bit timing, start and stop bit checks,
 LSB first shifting and one-cycle byte events.
*/

`timescale 1ns/1ps

module uart_rx_sampler
	import uart_rx_pkg::*;
#(
	parameter int FREQUENCY = 50_000_000,
	parameter int BAUDRATE = 115_200
)(
	input  logic      i_clock,
	input  logic      i_reset,
	input  logic      i_rx,
	output rx_event_t o_event
);

	localparam int PRESCALE = FREQUENCY / (BAUDRATE * 8);
	localparam int BIT_CYCLES = PRESCALE * 8;
	localparam int COUNT_WIDTH = $clog2(BIT_CYCLES);

	typedef logic [COUNT_WIDTH-1:0] count_t;

	// Full bit period and the delay to the start bit midpoint.
	localparam count_t BIT_RELOAD = count_t'(BIT_CYCLES - 1);
	localparam count_t HALF_RELOAD = count_t'(PRESCALE * 4 - 2);

	// Bit index counts down: start check, 8 data bits, stop check.
	localparam logic [3:0] START_INDEX = 4'd10;
	localparam logic [3:0] STOP_INDEX = 4'd1;

	logic rx_q;
	count_t prescale;
	logic [3:0] bit_index;
	byte_t shift;
	logic strobe;
	logic soft_reset;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rx_q <= 1'b1;
			prescale <= '0;
			bit_index <= '0;
			strobe <= 1'b0;
			soft_reset <= 1'b0;
		end
		else begin
			rx_q <= i_rx;
			strobe <= 1'b0;
			soft_reset <= 1'b0;

			if (prescale != '0) begin
				prescale <= prescale - 1'b1;
			end
			else if (bit_index == START_INDEX) begin
				if (!rx_q) begin
					// Start bit still low at its midpoint.
					bit_index <= bit_index - 1'b1;
					prescale <= BIT_RELOAD;
				end
				else begin
					// Glitch, back to idle.
					bit_index <= '0;
				end
			end
			else if (bit_index > STOP_INDEX) begin
				bit_index <= bit_index - 1'b1;
				prescale <= BIT_RELOAD;
				shift <= {rx_q, shift[7:1]};
			end
			else if (bit_index == STOP_INDEX) begin
				bit_index <= '0;
				// A low stop bit drops the frame.
				if (rx_q) begin
					strobe <= 1'b1;
					soft_reset <= (shift == 8'hff);
				end
			end
			else if (!rx_q) begin
				// Falling edge, wait for the start bit midpoint.
				prescale <= HALF_RELOAD;
				bit_index <= START_INDEX;
			end
		end
	end

	// The shift register holds the byte until the next start bit.
	assign o_event = '{strobe: strobe, data: shift, soft_reset: soft_reset};

endmodule

// File: verilog/rx_byte_fifo.sv
/*
 Synchronous byte FIFO.
 Circular buffer with registered read data, flush,
 and empty and full flags.
*/

`timescale 1ns/1ps

module rx_byte_fifo
	import uart_rx_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
)(
	input  logic         i_clock,
	input  logic         i_reset,
	input  logic         i_flush,
	input  logic         i_write,
	input  byte_t        i_wdata,
	input  logic         i_read,
	output byte_t        o_rdata,
	output fifo_status_t o_status
);

	localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

	typedef logic [PTR_WIDTH-1:0] ptr_t;
	typedef logic [PTR_WIDTH:0] count_t;

	localparam count_t DEPTH_COUNT = count_t'(FIFO_DEPTH);

	byte_t mem [FIFO_DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	count_t count;
	logic do_write;
	logic do_read;

	assign o_status.empty = (count == '0);
	assign o_status.full = (count == DEPTH_COUNT);

	// Full drops the write, empty ignores the read.
	assign do_write = i_write && !o_status.full;
	assign do_read = i_read && !o_status.empty;

	always_ff @(posedge i_clock) begin
		if (i_reset || i_flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_write && !do_read) begin
				count <= count + 1'b1;
			end
			else if (do_read && !do_write) begin
				count <= count - 1'b1;
			end
		end
	end

	// Storage and read register.
	always_ff @(posedge i_clock) begin
		if (do_write && !i_flush) begin
			mem[wr_ptr] <= i_wdata;
		end
		if (do_read) begin
			o_rdata <= mem[rd_ptr];
		end
	end

endmodule

// File: verilog/uart_rx_regs.sv
/*
 Register read port control.
 FSM that decodes the address, pops the FIFO,
 builds status and signature words and issues the flush.
*/

`timescale 1ns/1ps

module uart_rx_regs
	import uart_rx_pkg::*;
(
	input  logic         i_clock,
	input  logic         i_reset,
	input  logic         i_request,
	input  reg_addr_t    i_address,
	input  fifo_status_t i_fifo_status,
	input  byte_t        i_fifo_rdata,
	output logic         o_fifo_read,
	output logic         o_fifo_flush,
	output bus_word_t    o_rdata,
	output logic         o_ready
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_POP,
		ST_FETCH,
		ST_LOAD,
		ST_DONE
	} state_t;

	state_t state;
	bus_word_t status_word;

	// Status word from the FIFO flags.
	always_comb begin
		status_word = '0;
		status_word[STATUS_EMPTY_BIT] = i_fifo_status.empty;
		status_word[STATUS_FULL_BIT] = i_fifo_status.full;
	end

	// Pop is a single cycle, POP is never held.
	assign o_fifo_read = (state == ST_POP);

	// Word is loaded in LOAD and held in DONE.
	assign o_ready = i_request && (state == ST_LOAD || state == ST_DONE);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_fifo_flush <= 1'b0;
		end
		else begin
			o_fifo_flush <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (i_request) begin
						case (i_address)
							ADDR_DATA: begin
								// Stay idle until a byte is queued.
								if (!i_fifo_status.empty) begin
									state <= ST_POP;
								end
							end
							ADDR_STATUS: begin
								o_rdata <= status_word;
								state <= ST_LOAD;
							end
							ADDR_FLUSH: begin
								o_rdata <= FLUSH_SIGNATURE;
								o_fifo_flush <= 1'b1;
								state <= ST_LOAD;
							end
							default: begin
								o_rdata <= '0;
								state <= ST_LOAD;
							end
						endcase
					end
				end
				ST_POP: begin
					// FIFO registers the head byte on this edge.
					state <= ST_FETCH;
				end
				ST_FETCH: begin
					o_rdata <= {24'b0, i_fifo_rdata};
					state <= ST_LOAD;
				end
				ST_LOAD, ST_DONE: begin
					// Hold until the requester lets go.
					state <= i_request ? ST_DONE : ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: verilog/uart_rx_top.sv
/*
 UART receive peripheral top level.
 Connects the deserializer, byte FIFO and register control.
*/

`timescale 1ns/1ps

module uart_rx_top
	import uart_rx_pkg::*;
#(
	parameter int FREQUENCY = 50_000_000,
	parameter int BAUDRATE = 115_200,
	parameter int FIFO_DEPTH = 16
)(
	input  logic      i_clock,
	input  logic      i_reset,
	input  logic      i_request,
	input  reg_addr_t i_address,
	output bus_word_t o_rdata,
	output logic      o_ready,
	output logic      o_interrupt,
	output logic      o_soft_reset,
	input  logic      i_rx
);

	rx_event_t rx_event;
	fifo_status_t fifo_status;
	byte_t fifo_rdata;
	logic fifo_read;
	logic fifo_flush;

	uart_rx_sampler #(
		.FREQUENCY(FREQUENCY),
		.BAUDRATE(BAUDRATE)
	) u_sampler (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rx(i_rx),
		.o_event(rx_event)
	);

	rx_byte_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_flush(fifo_flush),
		.i_write(rx_event.strobe),
		.i_wdata(rx_event.data),
		.i_read(fifo_read),
		.o_rdata(fifo_rdata),
		.o_status(fifo_status)
	);

	uart_rx_regs u_regs (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_address(i_address),
		.i_fifo_status(fifo_status),
		.i_fifo_rdata(fifo_rdata),
		.o_fifo_read(fifo_read),
		.o_fifo_flush(fifo_flush),
		.o_rdata(o_rdata),
		.o_ready(o_ready)
	);

	// Interrupt pulses even when the FIFO drops the byte.
	assign o_interrupt = rx_event.strobe;
	assign o_soft_reset = rx_event.strobe && rx_event.soft_reset;

endmodule

// File: tb/uart_rx_assert.sv
/*
 Concurrent checks on the register port control,
 bound into every uart_rx_regs instance.
*/

`timescale 1ns/1ps

module uart_rx_assert
	import uart_rx_pkg::*;
(
	input logic         i_clock,
	input logic         i_reset,
	input logic         i_request,
	input fifo_status_t i_fifo_status,
	input logic         o_fifo_read,
	input logic         o_fifo_flush,
	input bus_word_t    o_rdata,
	input logic         o_ready
);

	// Ready never comes in the first cycle of a request.
	ready_needs_held_request: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |-> $past(i_request))
		else $error("o_ready high in the first cycle of i_request");

	pop_not_empty: assert property (@(posedge i_clock) disable iff (i_reset)
		o_fifo_read |-> !i_fifo_status.empty)
		else $error("FIFO pop while empty");

	// Read word holds while ready stays up.
	rdata_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |=> (!o_ready || $stable(o_rdata)))
		else $error("o_rdata changed while o_ready high");

	flush_single: assert property (@(posedge i_clock) disable iff (i_reset)
		o_fifo_flush |=> !o_fifo_flush)
		else $error("FIFO flush longer than one cycle");

endmodule

bind uart_rx_regs uart_rx_assert u_assert (.*);

// File: tb/tb_uart_rx.sv
/*
 Testbench for the UART receive peripheral.
 Clock, reset, LFSR stimulus, frame driver, read tasks,
 reference model, pulse counting and watchdog.
*/

`timescale 1ns/1ps

module tb_uart_rx
	import uart_rx_pkg::*;
;

	localparam int FREQUENCY = 50_000_000;
	localparam int BAUDRATE = 3_125_000;
	localparam int FIFO_DEPTH = 4;
	localparam int BIT_CYCLES = 16;
	localparam int NUM_FRAMES = 14;
	localparam int NUM_READS = 17;
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * 10 * BIT_CYCLES + NUM_READS * 10 + 1000;

	logic i_clock = 1'b0;
	logic i_reset;
	logic i_request;
	reg_addr_t i_address;
	logic i_rx;
	bus_word_t o_rdata;
	logic o_ready;
	logic o_interrupt;
	logic o_soft_reset;

	logic [31:0] lfsr_state = 32'h23be_c2ac;
	byte_t model_q[$];
	int irq_expected = 0;
	int irq_seen = 0;
	int soft_expected = 0;
	int soft_seen = 0;
	int error_count = 0;
	int check_count = 0;
	int last_latency;

	uart_rx_top #(
		.FREQUENCY(FREQUENCY),
		.BAUDRATE(BAUDRATE),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_dut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_address(i_address),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_interrupt(o_interrupt),
		.o_soft_reset(o_soft_reset),
		.i_rx(i_rx)
	);

	always #10 i_clock = ~i_clock;

	// Fibonacci LFSR, taps 32 22 2 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic random_byte(output byte_t value);
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value[i] = lfsr_state[0];
		end
	endtask

	// Expected read word for an address, from the model queue.
	function automatic bus_word_t expected_word(input reg_addr_t addr);
		bus_word_t word;
		word = '0;
		case (addr)
			ADDR_DATA: word = {24'b0, model_q[0]};
			ADDR_STATUS: begin
				word[STATUS_EMPTY_BIT] = (model_q.size() == 0);
				word[STATUS_FULL_BIT] = (model_q.size() == FIFO_DEPTH);
			end
			ADDR_FLUSH: word = FLUSH_SIGNATURE;
			default: word = '0;
		endcase
		return word;
	endfunction

	// Start bit, 8 data bits LSB first, stop bit.
	task automatic send_frame(input byte_t value, input bit bad_stop);
		if (!bad_stop) begin
			irq_expected++;
			if (value == 8'hff)
				soft_expected++;
			// A byte that finds the FIFO full is lost.
			if (model_q.size() < FIFO_DEPTH)
				model_q.push_back(value);
		end
		@(posedge i_clock);
		#2 i_rx = 1'b0;
		repeat (BIT_CYCLES) @(posedge i_clock);
		for (int i = 0; i < 8; i++) begin
			#2 i_rx = value[i];
			repeat (BIT_CYCLES) @(posedge i_clock);
		end
		if (bad_stop) begin
			// Low over the stop sample, high again before the
			// receiver rechecks the false start edge that follows.
			#2 i_rx = 1'b0;
			repeat (12) @(posedge i_clock);
		end
		#2 i_rx = 1'b1;
		repeat (BIT_CYCLES + 4) @(posedge i_clock);
	endtask

	// Hold the request until ready, take the word, let go.
	task automatic bus_read(input reg_addr_t addr, output bus_word_t word, output int latency);
		@(posedge i_clock);
		#2;
		i_request = 1'b1;
		i_address = addr;
		latency = 0;
		do begin
			@(posedge i_clock);
			#1;
			latency++;
		end while (!o_ready);
		word = o_rdata;
		#1;
		i_request = 1'b0;
	endtask

	task automatic check_read(input string name, input reg_addr_t addr, input bit may_wait);
		bus_word_t got;
		bus_word_t expected;
		int latency;
		int expected_latency;
		bus_read(addr, got, latency);
		last_latency = latency;
		expected = expected_word(addr);
		expected_latency = (addr == ADDR_DATA) ? 3 : 1;
		check_count++;
		if (got !== expected) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, got);
			error_count++;
		end
		if (!may_wait && latency != expected_latency) begin
			$display("FAILED %s latency: expected %0d, actual %0d", name, expected_latency, latency);
			error_count++;
		end
		if (addr == ADDR_DATA && model_q.size() > 0)
			void'(model_q.pop_front());
		else if (addr == ADDR_FLUSH)
			model_q.delete();
	endtask

	task automatic check_pulses(input string name);
		check_count++;
		if (irq_seen != irq_expected) begin
			$display("FAILED %s interrupts: expected %0d, actual %0d", name, irq_expected, irq_seen);
			error_count++;
		end
		if (soft_seen != soft_expected) begin
			$display("FAILED %s soft resets: expected %0d, actual %0d", name, soft_expected,
				soft_seen);
			error_count++;
		end
	endtask

	// Pulses sampled away from the active edge.
	always @(negedge i_clock) begin
		if (!i_reset) begin
			if (o_interrupt) begin
				irq_seen++;
				if (irq_seen > irq_expected) begin
					$display("Interrupt pulse without a good frame on the line");
					error_count++;
				end
			end
			if (o_soft_reset) begin
				soft_seen++;
				if (soft_seen > soft_expected) begin
					$display("Soft reset pulse without a 0xFF byte on the line");
					error_count++;
				end
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge i_clock);
		$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Something failed");
		$finish;
	end

	initial begin
		byte_t b;
		i_reset = 1'b1;
		i_request = 1'b0;
		i_address = ADDR_DATA;
		i_rx = 1'b1;
		repeat (5) @(posedge i_clock);
		#2 i_reset = 1'b0;

		// Three random bytes, read back in order.
		for (int i = 0; i < 3; i++) begin
			random_byte(b);
			send_frame(b, 1'b0);
		end
		for (int i = 0; i < 3; i++)
			check_read("random_bytes", ADDR_DATA, 1'b0);
		check_pulses("random_bytes");

		// Flags, then one byte past full.
		check_read("status_empty", ADDR_STATUS, 1'b0);
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			random_byte(b);
			send_frame(b, 1'b0);
		end
		check_read("status_full", ADDR_STATUS, 1'b0);
		random_byte(b);
		send_frame(b, 1'b0);
		for (int i = 0; i < FIFO_DEPTH; i++)
			check_read("overflow_data", ADDR_DATA, 1'b0);
		check_read("status_drained", ADDR_STATUS, 1'b0);
		check_pulses("overflow");

		send_frame(8'hff, 1'b0);
		random_byte(b);
		send_frame(b, 1'b0);
		check_read("soft_reset_data", ADDR_DATA, 1'b0);
		check_read("soft_reset_data", ADDR_DATA, 1'b0);
		check_pulses("soft_reset");

		random_byte(b);
		send_frame(b, 1'b1);
		check_read("bad_stop_status", ADDR_STATUS, 1'b0);
		check_pulses("bad_stop");

		for (int i = 0; i < 2; i++) begin
			random_byte(b);
			send_frame(b, 1'b0);
		end
		check_read("flush", ADDR_FLUSH, 1'b0);
		check_read("status_after_flush", ADDR_STATUS, 1'b0);
		check_read("unknown_address", 2'd3, 1'b0);

		// Data read parked on an empty FIFO.
		random_byte(b);
		fork
			check_read("wait_for_byte", ADDR_DATA, 1'b1);
			begin
				repeat (20) @(posedge i_clock);
				send_frame(b, 1'b0);
			end
		join
		check_count++;
		if (last_latency <= 9 * BIT_CYCLES) begin
			$display("Ready came after %0d cycles, before the byte could arrive", last_latency);
			error_count++;
		end
		check_pulses("wait_for_byte");

		$display("Checks: %0d, errors: %0d, interrupts: %0d, soft resets: %0d",
			check_count, error_count, irq_seen, soft_seen);
		if (error_count == 0) begin
			$display("Everything OK");
		end
		else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: all.f
verilog/uart_rx_pkg.sv
verilog/uart_rx_sampler.sv
verilog/rx_byte_fifo.sv
verilog/uart_rx_regs.sv
verilog/uart_rx_top.sv
tb/uart_rx_assert.sv
tb/tb_uart_rx.sv

// File: Bender.yml
package:
  name: uart_rx

sources:
  - verilog/uart_rx_pkg.sv
  - verilog/uart_rx_sampler.sv
  - verilog/rx_byte_fifo.sv
  - verilog/uart_rx_regs.sv
  - verilog/uart_rx_top.sv
  - target: test
    files:
      - tb/uart_rx_assert.sv
      - tb/tb_uart_rx.sv
